// File: Makefile
VERILATOR  ?= verilator
TOP        := tbStreamEngine
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TEST RESULT: PASS
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/engineRegs.sv
/*
 * Wishbone classic config slave, one access every 2 cycles (ack, then a gap).
 * CMD writes while busy are dropped. irq has no clear of its own and
 * stays high from job end until the next start.
 */
`timescale 1ns/1ps
`default_nettype none

module engineRegs import streamPkg::*; (
    input  logic    CLK,
    input  logic    ARESETN,
    input  wbReq_t  wbReq,
    output wbRsp_t  wbRsp,
    input  logic    shimDone,
    input  logic    padded,
    output jobCfg_t job,
    output logic    start,
    output logic    irq
);

    logic                 ackQ;
    logic [WB_DATA_W-1:0] datRQ;
    logic [SHIFT_W-1:0]   lenShift;
    logic [COUNT_W-1:0]   lenCount;
    logic                 busy;
    logic                 done;
    logic                 paddedQ;
    logic                 wbHit;
    logic                 wbWr;
    logic                 cmdTake;
    logic [SHIFT_W-1:0]   wrShiftRaw;
    logic [SHIFT_W-1:0]   wrShift;
    logic [WB_DATA_W-1:0] rdMux;

    assign wbHit      = wbReq.cyc && wbReq.stb;
    assign wbWr       = wbHit && wbReq.we && ackQ;           // lands on the ack edge
    assign cmdTake    = wbWr && (wbReq.adr == REG_CMD) && !busy;
    assign wrShiftRaw = wbReq.datW[WB_DATA_W-1 -: SHIFT_W];
    assign wrShift    = (wrShiftRaw > SHIFT_W'(MAX_SHIFT)) ? SHIFT_W'(MAX_SHIFT) : wrShiftRaw;

    always_comb begin
        case (wbReq.adr)
            REG_CMD:    rdMux = WB_DATA_W'(job.op);
            REG_LEN:    rdMux = {lenShift, lenCount};
            REG_STATUS: rdMux = {{(WB_DATA_W-3){1'b0}}, paddedQ, done, busy};
            default:    rdMux = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // bus handshake, ack one cycle after request and never two in a row
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= wbHit && !ackQ;
        end
    end

    always_ff @(posedge CLK) begin
        if (wbHit && !ackQ) begin
            datRQ <= rdMux;                                  // read data rides with ack
        end
    end

    assign wbRsp = '{ack: ackQ, datR: datRQ};

    // ------------------------------------------------------------------------
    // LEN register, job state and status
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            lenShift <= '0;
            lenCount <= '0;
            start    <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            paddedQ  <= 1'b0;
        end else begin
            start <= cmdTake;                                // one cycle after the ack
            if (wbWr && (wbReq.adr == REG_LEN)) begin
                lenShift <= wrShift;
                lenCount <= wbReq.datW[COUNT_W-1:0];
            end
            if (cmdTake) begin
                busy    <= 1'b1;
                done    <= 1'b0;                             // status clears on start
                paddedQ <= 1'b0;
            end else if (shimDone && busy) begin
                busy    <= 1'b0;
                done    <= 1'b1;
                paddedQ <= padded;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cmdTake) begin
            job.op       <= kernelOp_e'(wbReq.datW[1:0]);
            job.shift    <= lenShift;
            job.inWords  <= lenCount;
            job.outWords <= lenCount >> lenShift;            // same rule as the reference
        end
    end

    assign irq = done;

endmodule

`default_nettype wire

// File: src/inputGate.sv
/*
 * Lets exactly job.inWords words through after each start, then closes.
 * Words offered past the job length are left on the input, never taken.
 */
`timescale 1ns/1ps
`default_nettype none

module inputGate import streamPkg::*; (
    input  logic        CLK,
    input  logic        ARESETN,
    input  logic        start,
    input  jobCfg_t     job,
    input  streamBeat_t inBeat,
    output logic        inReady,
    output streamBeat_t gateBeat,
    input  logic        gateReady
);

    logic [COUNT_W-1:0] remaining;   // words still owed to the kernel
    logic               open;

    assign open     = (remaining != '0);
    assign inReady  = open && gateReady;                     // kernel back-pressure passes up
    assign gateBeat = '{valid: open && inBeat.valid, data: inBeat.data};

    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            remaining <= '0;
        end else if (start) begin
            remaining <= job.inWords;                        // ready from next cycle
        end else if (inBeat.valid && inReady) begin
            remaining <= remaining - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/outputShim.sv
/*
 * Delivers exactly job.outWords words downstream. If the kernel stays quiet
 * for more than SHIM_WAIT_CYCLES while words are owed, the rest is FILL_WORD.
 * Stalls under back-pressure never count as idle. Late kernel words are dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module outputShim import streamPkg::*; (
    input  logic        CLK,
    input  logic        ARESETN,
    input  logic        start,
    input  jobCfg_t     job,
    input  streamBeat_t kernBeat,
    output logic        kernReady,
    output streamBeat_t outBeat,
    input  logic        outReady,
    output logic        shimDone,
    output logic        padded
);

    logic [COUNT_W-1:0] remaining;   // output words still owed
    logic               active;
    logic               fill;        // underflow, pad the rest
    logic [IDLE_W-1:0]  idleCnt;
    logic               pending;
    logic               outFire;
    logic               idle;

    assign pending   = active && (remaining != '0);
    assign outBeat   = '{valid: pending && (fill || kernBeat.valid),
                         data:  fill ? FILL_WORD : kernBeat.data};
    assign kernReady = active && (fill || (pending && outReady));  // fill swallows kernel
    assign outFire   = outBeat.valid && outReady;
    assign idle      = pending && !fill && !kernBeat.valid;
    assign shimDone  = active && (remaining == '0);                // one cycle, active drops
    assign padded    = fill;

    // ------------------------------------------------------------------------
    // word count, idle timeout and fill mode
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            active    <= 1'b0;
            remaining <= '0;
            fill      <= 1'b0;
            idleCnt   <= '0;
        end else if (start) begin
            active    <= 1'b1;
            remaining <= job.outWords;
            fill      <= 1'b0;
            idleCnt   <= '0;
        end else begin
            if (shimDone) begin
                active <= 1'b0;
            end
            if (outFire) begin
                remaining <= remaining - 1'b1;
            end
            if (outFire) begin
                idleCnt <= '0;                               // any accepted word rearms
            end else if (idle) begin
                if (idleCnt == IDLE_W'(SHIM_WAIT_CYCLES)) begin
                    fill <= 1'b1;                            // sticky until next start
                end else begin
                    idleCnt <= idleCnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/reduceKernel.sv
/*
 * Reduces each group of 2^shift words into one output word.
 * One output register, so a finished group can wait while the next one builds.
 * A trailing partial group is never emitted and is dropped by the next start.
 */
`timescale 1ns/1ps
`default_nettype none

module reduceKernel import streamPkg::*; (
    input  logic        CLK,
    input  logic        ARESETN,
    input  logic        start,
    input  jobCfg_t     job,
    input  streamBeat_t gateBeat,
    output logic        gateReady,
    output streamBeat_t kernBeat,
    input  logic        kernReady
);

    logic [DATA_W-1:0]    acc;
    logic [MAX_SHIFT-1:0] pos;        // index within the current group
    logic [MAX_SHIFT-1:0] lastPos;
    logic                 outValid;
    logic [DATA_W-1:0]    outData;
    logic                 groupEnd;
    logic                 outFree;
    logic                 inFire;
    logic [DATA_W-1:0]    combined;

    function automatic logic [DATA_W-1:0] combine(kernelOp_e op, logic [DATA_W-1:0] a,
                                                  logic [DATA_W-1:0] b);
        case (op)
            OP_SUM:  return a + b;
            OP_XOR:  return a ^ b;
            OP_MAX:  return (b > a) ? b : a;
            default: return (b < a) ? b : a;                 // OP_MIN
        endcase
    endfunction

    assign lastPos   = MAX_SHIFT'((1 << job.shift) - 1);
    assign groupEnd  = (pos == lastPos);
    assign outFree   = !outValid || kernReady;               // empty or draining now
    assign gateReady = !groupEnd || outFree;                 // only the closing word can stall
    assign inFire    = gateBeat.valid && gateReady;
    assign combined  = (pos == '0) ? gateBeat.data : combine(job.op, acc, gateBeat.data);
    assign kernBeat  = '{valid: outValid, data: outData};

    // ------------------------------------------------------------------------
    // group position and output valid
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            pos      <= '0;
            outValid <= 1'b0;
        end else if (start) begin
            pos      <= '0;                                  // drop partial group
            outValid <= 1'b0;                                // and any stale result
        end else begin
            if (inFire) begin
                pos <= groupEnd ? '0 : pos + 1'b1;
            end
            if (inFire && groupEnd) begin
                outValid <= 1'b1;                            // refill while draining
            end else if (kernReady) begin
                outValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (inFire) begin
            if (groupEnd) begin
                outData <= combined;
            end else begin
                acc <= combined;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/streamEngine.sv
/*
 * Stream engine top: Wishbone config, input gate, reduction kernel, output shim.
 * Data path is valid/ready, one 64-bit word per transfer.
 * irq is level, high from job end until the next CMD write.
 */
`timescale 1ns/1ps
`default_nettype none

module streamEngine import streamPkg::*; (
    input  logic        CLK,
    input  logic        ARESETN,
    input  wbReq_t      wbReq,
    output wbRsp_t      wbRsp,
    input  streamBeat_t inBeat,
    output logic        inReady,
    output streamBeat_t outBeat,
    input  logic        outReady,
    output logic        irq
);

    jobCfg_t     job;          // latched on CMD write
    logic        start;        // one-cycle job start
    logic        shimDone;
    logic        padded;
    streamBeat_t gateBeat;
    logic        gateReady;
    streamBeat_t kernBeat;
    logic        kernReady;

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    engineRegs u_regs (
        .CLK      (CLK),
        .ARESETN  (ARESETN),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .shimDone (shimDone),
        .padded   (padded),
        .job      (job),
        .start    (start),
        .irq      (irq)
    );

    // ------------------------------------------------------------------------
    // data path, input -> gate -> kernel -> shim -> output
    // ------------------------------------------------------------------------
    inputGate u_gate (
        .CLK       (CLK),
        .ARESETN   (ARESETN),
        .start     (start),
        .job       (job),
        .inBeat    (inBeat),
        .inReady   (inReady),
        .gateBeat  (gateBeat),
        .gateReady (gateReady)
    );

    reduceKernel u_kernel (
        .CLK       (CLK),
        .ARESETN   (ARESETN),
        .start     (start),
        .job       (job),
        .gateBeat  (gateBeat),
        .gateReady (gateReady),
        .kernBeat  (kernBeat),
        .kernReady (kernReady)
    );

    outputShim u_shim (
        .CLK       (CLK),
        .ARESETN   (ARESETN),
        .start     (start),
        .job       (job),
        .kernBeat  (kernBeat),
        .kernReady (kernReady),
        .outBeat   (outBeat),
        .outReady  (outReady),
        .shimDone  (shimDone),
        .padded    (padded)
    );

endmodule

`default_nettype wire

// File: src/streamPkg.sv
/*
 * Shared widths, register map and types of the stream engine.
 * LEN word is {shift[31:28], inWords[27:0]}, and a shift above MAX_SHIFT is capped.
 * Max and min compare words as unsigned 64-bit values.
 */
`default_nettype none

package streamPkg;

    // ------------------------------------------------------------------------
    // widths and limits
    // ------------------------------------------------------------------------
    localparam int DATA_W    = 64;                 // stream word
    localparam int WB_ADDR_W = 4;                  // byte offsets 0x0..0xc
    localparam int WB_DATA_W = 32;
    localparam int COUNT_W   = 28;                 // LEN[27:0]
    localparam int SHIFT_W   = 4;                  // LEN[31:28]
    localparam int MAX_SHIFT = 4;                  // groups of at most 16 words

    localparam logic [WB_ADDR_W-1:0] REG_CMD    = 4'h0;  // write starts a job
    localparam logic [WB_ADDR_W-1:0] REG_LEN    = 4'h4;
    localparam logic [WB_ADDR_W-1:0] REG_STATUS = 4'h8;  // {padded, done, busy}

    localparam logic [DATA_W-1:0] FILL_WORD = 64'hDEAD_BEEF_DEAD_BEEF;  // underflow pad
    localparam int SHIM_WAIT_CYCLES = 64;          // idle cycles before padding
    localparam int IDLE_W = $clog2(SHIM_WAIT_CYCLES) + 1;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_SUM = 2'd0,                             // wraps at 64 bits
        OP_XOR = 2'd1,
        OP_MAX = 2'd2,
        OP_MIN = 2'd3
    } kernelOp_e;

    typedef struct packed {
        kernelOp_e          op;
        logic [SHIFT_W-1:0] shift;                 // already capped
        logic [COUNT_W-1:0] inWords;
        logic [COUNT_W-1:0] outWords;              // inWords >> shift
    } jobCfg_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] datW;
    } wbReq_t;

    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] datR;
    } wbRsp_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } streamBeat_t;

endpackage

`default_nettype wire

// File: test/streamEngine_asserts.sv
/*
 * Concurrent checks bound into streamEngine.
 * Covers output stream stability, Wishbone ack width and the idle timeout
 * before fill mode. Quiet cycles are counted here from start and the streams.
 */
`timescale 1ns/1ps
`default_nettype none

module streamEngine_asserts import streamPkg::*; (
    input logic        CLK,
    input logic        ARESETN,
    input wbRsp_t      wbRsp,
    input streamBeat_t outBeat,
    input logic        outReady,
    input logic        start,
    input streamBeat_t kernBeat,
    input logic        padded      // shim fill mode
);

    int quietCnt;                  // cycles with no kernel word and no output word

    always_ff @(posedge CLK) begin
        if (!ARESETN) begin
            quietCnt <= 0;
        end else if (start || (outBeat.valid && outReady)) begin
            quietCnt <= 0;                                   // new job or word accepted
        end else if (!kernBeat.valid) begin
            quietCnt <= quietCnt + 1;
        end
    end

    // stalled word stays put
    assert property (@(posedge CLK) disable iff (!ARESETN)
        (outBeat.valid && !outReady) |=> (outBeat.valid && $stable(outBeat.data)))
        else $error("outBeat changed while outReady was low");

    assert property (@(posedge CLK) disable iff (!ARESETN)
        wbRsp.ack |=> !wbRsp.ack)
        else $error("Wishbone ack high for two cycles");

    assert property (@(posedge CLK) disable iff (!ARESETN)
        $rose(padded) |-> (quietCnt >= SHIM_WAIT_CYCLES))
        else $error("fill mode entered before the idle timeout");

endmodule

bind streamEngine streamEngine_asserts u_asserts (
    .CLK      (CLK),
    .ARESETN  (ARESETN),
    .wbRsp    (wbRsp),
    .outBeat  (outBeat),
    .outReady (outReady),
    .start    (start),
    .kernBeat (kernBeat),
    .padded   (padded)
);

`default_nettype wire

// File: test/tbStreamEngine.sv
/*
 * Testbench for streamEngine. Jobs are set up over Wishbone, and the input and
 * output streams run in separate processes. Expected words come from a reference
 * reduction over the stored inputs. Random data and ready gaps come from LFSRs
 * seeded with 45. A watchdog ends the run if a job never completes.
 */
`timescale 1ns/1ps
`default_nettype none

module tbStreamEngine import streamPkg::*; ();

    localparam int TOTAL_WORDS     = 172;               // input words over all jobs
    localparam int NUM_JOBS        = 7;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + NUM_JOBS * (SHIM_WAIT_CYCLES + 40) + 200;

    logic        CLK;
    logic        ARESETN;
    wbReq_t      wbReq;
    wbRsp_t      wbRsp;
    streamBeat_t inBeat;
    logic        inReady;
    streamBeat_t outBeat;
    logic        outReady;
    logic        irq;

    logic [DATA_W-1:0] inWords[$];                      // words fed in the current job
    logic [DATA_W-1:0] expWords[$];                     // outputs still expected
    logic [DATA_W-1:0] expWord;
    logic [31:0]       dataLfsr;
    logic [31:0]       readyLfsr;
    bit                gapMode;                         // random outReady gaps
    int                tbErrs;
    int                checkErrs;                       // counted by the output checker
    int                testsRun;
    int                testsFailed;

    streamEngine u_dut (
        .CLK      (CLK),
        .ARESETN  (ARESETN),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .inBeat   (inBeat),
        .inReady  (inReady),
        .outBeat  (outBeat),
        .outReady (outReady),
        .irq      (irq)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;                              // 20 ns period

    // ------------------------------------------------------------------------
    // random numbers and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [DATA_W-1:0] randomWord();
        logic [DATA_W-1:0] w;
        w = '0;
        for (int b = 0; b < DATA_W; b++) begin
            dataLfsr = lfsrNext(dataLfsr);              // one step per bit
            w = {w[DATA_W-2:0], dataLfsr[0]};
        end
        return w;
    endfunction

    // one output word from group number grp of the stored inputs
    function automatic logic [DATA_W-1:0] refReduce(kernelOp_e op, int shift, int grp);
        logic [DATA_W-1:0] acc;
        logic [DATA_W-1:0] w;
        int                base;
        base = grp << shift;
        acc  = inWords[base];
        for (int k = 1; k < (1 << shift); k++) begin
            w = inWords[base + k];
            case (op)
                OP_SUM:  acc = acc + w;                 // mod 2^64
                OP_XOR:  acc = acc ^ w;
                OP_MAX:  acc = (w > acc) ? w : acc;     // unsigned
                default: acc = (w < acc) ? w : acc;
            endcase
        end
        return acc;
    endfunction

    function automatic int errTotal();
        return tbErrs + checkErrs;
    endfunction

    // ------------------------------------------------------------------------
    // check and report helpers
    // ------------------------------------------------------------------------
    task automatic expectWord(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", sig, got, exp);
            tbErrs++;
        end
    endtask

    task automatic expectBit(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", sig, got, exp);
            tbErrs++;
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testsRun++;
        if (errTotal() == errsBefore) begin
            $display("test %-28s ok", name);
        end else begin
            testsFailed++;
            $display("test %-28s failed with %0d errors", name, errTotal() - errsBefore);
        end
    endtask

    // ------------------------------------------------------------------------
    // Wishbone host
    // ------------------------------------------------------------------------
    task automatic busAccess(input bit write, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] wdat,
                             output logic [WB_DATA_W-1:0] rdat);
        int n;
        @(posedge CLK);
        wbReq <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, datW: wdat};
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!wbRsp.ack && n < 16);
        if (!wbRsp.ack) begin
            $display("Wishbone access to offset %h got no ack", adr);
            tbErrs++;
        end
        rdat = wbRsp.datR;                              // held with ack
        @(posedge CLK);                                 // write lands on this edge
        wbReq <= '0;
    endtask

    task automatic writeReg(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
        logic [WB_DATA_W-1:0] rdIgnored;
        busAccess(1'b1, adr, data, rdIgnored);
    endtask

    task automatic readReg(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] data);
        busAccess(1'b0, adr, '0, data);
    endtask

    // ------------------------------------------------------------------------
    // job steps
    // ------------------------------------------------------------------------
    task automatic prepareJob(input kernelOp_e op, input int shift, input int nIn,
                              input int nFeed, output bit padExp);
        int nOut;
        int nFull;
        nOut  = nIn >> shift;
        nFull = nFeed >> shift;                         // groups the kernel can finish
        inWords.delete();
        for (int i = 0; i < nFeed; i++) begin
            inWords.push_back(randomWord());
        end
        for (int g = 0; g < nFull; g++) begin
            expWords.push_back(refReduce(op, shift, g));
        end
        for (int g = nFull; g < nOut; g++) begin
            expWords.push_back(FILL_WORD);              // underflow pad
        end
        padExp = (nFull < nOut);
    endtask

    task automatic startJob(input kernelOp_e op, input int shift, input int nIn);
        writeReg(REG_LEN, {SHIFT_W'(shift), COUNT_W'(nIn)});
        writeReg(REG_CMD, WB_DATA_W'(op));
    endtask

    task automatic sendWords();
        int n;
        @(posedge CLK);
        foreach (inWords[i]) begin
            inBeat <= '{valid: 1'b1, data: inWords[i]};
            n = 0;
            do begin
                @(negedge CLK);
                n++;
            end while (!inReady && n < 1000);
            if (!inReady) begin
                $display("input word %0d was never accepted", i);
                tbErrs++;
                break;
            end
            @(posedge CLK);                             // transfer edge
        end
        inBeat <= '0;
    endtask

    task automatic finishJob(input string name, input bit padExp, input int errsBefore,
                             input int nOut);
        logic [WB_DATA_W-1:0] status;
        int                   n;
        int                   limit;
        limit = nOut * 8 + SHIM_WAIT_CYCLES + 64;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!irq && n < limit);
        if (!irq) begin
            $display("irq did not rise within %0d cycles of the last input", limit);
            tbErrs++;
        end
        readReg(REG_STATUS, status);
        expectWord("STATUS after job", status, {29'd0, padExp, 1'b1, 1'b0});
        if (expWords.size() != 0) begin
            $display("%0d expected output words never arrived", expWords.size());
            tbErrs++;
            expWords.delete();
        end
        reportTest(name, errsBefore);
    endtask

    task automatic runJob(input string name, input kernelOp_e op, input int shift,
                          input int nIn, input int nFeed, input bit gaps);
        int errsBefore;
        bit padExp;
        errsBefore = errTotal();
        prepareJob(op, shift, nIn, nFeed, padExp);
        gapMode = gaps;
        startJob(op, shift, nIn);
        sendWords();
        finishJob(name, padExp, errsBefore, nIn >> shift);
        gapMode = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // output ready driver and output checker
    // ------------------------------------------------------------------------
    initial begin : readyDriver
        logic b0;
        logic b1;
        readyLfsr = 32'd45;
        outReady  = 1'b0;
        forever begin
            @(posedge CLK);
            if (gapMode) begin
                readyLfsr = lfsrNext(readyLfsr);
                b0 = readyLfsr[0];
                readyLfsr = lfsrNext(readyLfsr);
                b1 = readyLfsr[0];
                outReady <= b0 || b1;                   // low about a quarter of cycles
            end else begin
                outReady <= 1'b1;
            end
        end
    end

    always @(negedge CLK) begin
        if (ARESETN && outBeat.valid && outReady) begin // moves on the next edge
            if (expWords.size() == 0) begin
                $display("unexpected output word %h with none left to expect", outBeat.data);
                checkErrs++;
            end else begin
                expWord = expWords.pop_front();
                if (outBeat.data !== expWord) begin
                    $display("error outBeat.data got %h expected %h", outBeat.data, expWord);
                    checkErrs++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin : mainSequence
        logic [WB_DATA_W-1:0] rd;
        int                   errsBefore;
        ARESETN     = 1'b0;
        wbReq       = '0;
        inBeat      = '0;
        dataLfsr    = 32'd45;
        gapMode     = 1'b0;
        tbErrs      = 0;
        checkErrs   = 0;
        testsRun    = 0;
        testsFailed = 0;
        repeat (5) @(posedge CLK);
        ARESETN <= 1'b1;

        @(negedge CLK);
        errsBefore = errTotal();
        expectBit("wbRsp.ack", wbRsp.ack, 1'b0);
        expectBit("outBeat.valid", outBeat.valid, 1'b0);
        expectBit("inReady", inReady, 1'b0);
        expectBit("irq", irq, 1'b0);
        readReg(REG_STATUS, rd);
        expectWord("STATUS after reset", rd, 32'h0);
        reportTest("reset state", errsBefore);

        runJob("shift 0 sum pass-through", OP_SUM, 0, 16, 16, 1'b0);
        runJob("shift 2 sum", OP_SUM, 2, 32, 32, 1'b0);
        runJob("shift 2 max", OP_MAX, 2, 32, 32, 1'b0);
        runJob("shift 1 xor with gaps", OP_XOR, 1, 32, 32, 1'b1);
        runJob("shift 1 min with gaps", OP_MIN, 1, 32, 32, 1'b1);
        runJob("underflow pad", OP_SUM, 0, 24, 20, 1'b0);

        // registers, clear on start and CMD while busy
        errsBefore = errTotal();
        writeReg(REG_LEN, 32'h7000_0010);
        readReg(REG_LEN, rd);
        expectWord("LEN readback", rd, {SHIFT_W'(MAX_SHIFT), COUNT_W'(16)});
        prepareJob(OP_XOR, 1, 8, 8, gapMode);          // no pad, so gapMode stays 0
        startJob(OP_XOR, 1, 8);
        readReg(REG_STATUS, rd);
        expectWord("STATUS after start", rd, 32'h1);   // busy only, done and padded cleared
        @(negedge CLK);
        expectBit("irq after start", irq, 1'b0);
        writeReg(REG_CMD, WB_DATA_W'(OP_SUM));         // dropped while busy
        sendWords();
        finishJob("registers and busy CMD", 1'b0, errsBefore, 4);

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
                 errTotal());
        if (errTotal() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/streamPkg.sv
src/engineRegs.sv
src/inputGate.sv
src/reduceKernel.sv
src/outputShim.sv
src/streamEngine.sv
test/streamEngine_asserts.sv
test/tbStreamEngine.sv
